/* design/rv_isa_pkg.sv */
// RV32I base encodings only; no compressed forms, all immediates are sign-extended to 32 bits
package rv_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes, bits [6:0]
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // funct3 of the Zicsr forms under OPC_SYSTEM
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // addi x0,x0,0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////

  function automatic opcode_t get_opcode(instr_t i);
    return i[6:0];
  endfunction

  function automatic reg_t get_rd(instr_t i);
    return i[11:7];
  endfunction

  // Also the zimm field of the CSR immediate forms
  function automatic reg_t get_rs1(instr_t i);
    return i[19:15];
  endfunction

  function automatic reg_t get_rs2(instr_t i);
    return i[24:20];
  endfunction

  function automatic logic [2:0] get_funct3(instr_t i);
    return i[14:12];
  endfunction

  // Immediates, sign bit always at i[31]
  function automatic xlen_t imm_i(instr_t i);
    return {{20{i[31]}}, i[31:20]};
  endfunction

  function automatic xlen_t imm_s(instr_t i);
    return {{20{i[31]}}, i[31:25], i[11:7]};
  endfunction

  function automatic xlen_t imm_b(instr_t i);
    return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
  endfunction

  function automatic xlen_t imm_u(instr_t i);
    return {i[31:12], 12'h000};
  endfunction

  function automatic xlen_t imm_j(instr_t i);
    return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
  endfunction

endpackage

/* design/rv_pipe_pkg.sv */
// Front-end pipeline records; the PC is word aligned and the reset address is fixed at 0x200
package rv_pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] pc_t;

  // Reset fetch address
  localparam pc_t PC_INIT = 32'h0000_0200;

  //////////////////////////////////////////////////////////////////////
  // Stage records
  //////////////////////////////////////////////////////////////////////

  // Instruction with its kill flag
  typedef struct packed {
    rv_isa_pkg::instr_t instr;
    logic               bubble;
  } insn_t;

  // Issue exceptions; any is the OR of all causes
  typedef struct packed {
    logic illegal;
    logic any;
  } except_t;

  // Coarse operation class handed to the back end
  typedef enum logic [3:0] {
    ALU_REG,
    ALU_IMM,
    LOAD,
    STORE,
    BRANCH,
    JUMP,
    UPPER,
    SYSTEM,
    NONE
  } op_class_e;

  // Decoded operation record
  typedef struct packed {
    logic              valid;
    pc_t               pc;
    op_class_e         op_class;
    rv_isa_pkg::reg_t  rd;
    rv_isa_pkg::reg_t  rs1;
    rv_isa_pkg::reg_t  rs2;
    rv_isa_pkg::xlen_t imm;
    logic              pred_taken;
  } id_op_t;

endpackage

/* design/rv_fetch.sv */
// Instruction port is combinational and never waits; redirect targets must be word aligned
`timescale 1ns/1ns

module rv_fetch (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Control from pre-decode
  input  logic                   pd_stall_i,
  input  logic                   pd_flush_i,
  input  rv_pipe_pkg::pc_t       bu_nxt_pc_i,
  input  logic                   pd_latch_nxt_pc_i,
  input  rv_pipe_pkg::pc_t       pd_nxt_pc_i,

  // Instruction memory
  output rv_pipe_pkg::pc_t       imem_addr_o,
  input  rv_isa_pkg::instr_t     imem_data_i,

  // To pre-decode, same cycle
  output rv_pipe_pkg::insn_t     if_insn_o,
  output rv_pipe_pkg::pc_t       if_pc_o
);

  import rv_pipe_pkg::*;

  localparam pc_t PC_STEP = 32'd4;

  pc_t pc_q;
  pc_t pc_d;

  //////////////////////////////////////////////////////////////////////
  // Next PC
  //////////////////////////////////////////////////////////////////////

  // Branch-unit flush beats prediction, prediction beats hold
  always_comb begin
    if (pd_flush_i) begin
      pc_d = bu_nxt_pc_i;
    end else if (pd_latch_nxt_pc_i) begin
      pc_d = pd_nxt_pc_i;
    end else if (pd_stall_i) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + PC_STEP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= PC_INIT;
    end else begin
      pc_q <= pc_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign imem_addr_o = pc_q;
  assign if_pc_o     = pc_q;

  // Memory answers in the same cycle
  always_comb begin
    if_insn_o.instr  = imem_data_i;
    // Killing wrong-path words is left to pre-decode
    if_insn_o.bubble = 1'b0;
  end

  // Redirect sources must keep the PC on a word boundary
  a_pc_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_q[1:0] == 2'b00);

  // A flush always lands, whatever stall is active
  a_flush_lands : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_flush_i |=> pc_q == $past(bu_nxt_pc_i));

endmodule

/* design/rv_predecode.sv */
// Static prediction only (backward taken); back-to-back taken redirects cost one hold cycle
`timescale 1ns/1ns

module rv_predecode (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Pipeline control
  input  logic                   id_stall_i,
  output logic                   pd_stall_o,
  input  logic                   bu_flush_i,
  input  rv_pipe_pkg::pc_t       bu_nxt_pc_i,
  output logic                   pd_flush_o,

  // From fetch
  input  rv_pipe_pkg::insn_t     if_insn_i,
  input  rv_pipe_pkg::pc_t       if_pc_i,

  // From issue
  input  rv_pipe_pkg::except_t   id_except_i,

  // To issue, registered
  output rv_pipe_pkg::insn_t     pd_insn_o,
  output rv_pipe_pkg::pc_t       pd_pc_o,

  // Predicted redirect to fetch
  output rv_pipe_pkg::pc_t       pd_nxt_pc_o,
  output logic                   pd_latch_nxt_pc_o,
  output logic                   pd_pred_taken_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  reg_t       rs1;
  xlen_t      ext_imm_j;
  xlen_t      ext_imm_b;
  logic       is_jal;
  logic       is_branch;
  logic       branch_taken;
  logic       csr_write;
  logic       strobe_q;
  logic       redir_hold;
  logic       csr_stall_q;
  logic       local_stall;

  assign opcode    = get_opcode(if_insn_i.instr);
  assign funct3    = get_funct3(if_insn_i.instr);
  assign rs1       = get_rs1(if_insn_i.instr);
  assign ext_imm_j = imm_j(if_insn_i.instr);
  assign ext_imm_b = imm_b(if_insn_i.instr);

  assign pd_flush_o = bu_flush_i;

  //////////////////////////////////////////////////////////////////////
  // Static prediction
  //////////////////////////////////////////////////////////////////////

  assign is_jal    = ~if_insn_i.bubble & (opcode == OPC_JAL);
  assign is_branch = ~if_insn_i.bubble & (opcode == OPC_BRANCH);

  // JAL always, branch only when jumping backward
  assign branch_taken = is_jal | (is_branch & ext_imm_b[31]);

  // Target adder, JAL or branch offset
  assign pd_nxt_pc_o = if_pc_i + (is_jal ? ext_imm_j : ext_imm_b);

  // Strobe only when the jump is actually taken into the register
  assign pd_latch_nxt_pc_o = branch_taken & ~strobe_q & ~pd_stall_o & ~bu_flush_i;

  // Target right after a redirect is a taken jump again
  // hold it one cycle so the strobe can drop first
  assign redir_hold = branch_taken & strobe_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= pd_latch_nxt_pc_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CSR write stall
  //////////////////////////////////////////////////////////////////////

  // Writes that change state; zimm sits in the rs1 slot
  always_comb begin
    csr_write = 1'b0;
    if (opcode == OPC_SYSTEM) begin
      case (funct3)
        F3_CSRRW, F3_CSRRWI: csr_write = 1'b1;
        F3_CSRRS, F3_CSRRC:  csr_write = |rs1;
        F3_CSRRSI, F3_CSRRCI: csr_write = |rs1;
        default:             csr_write = 1'b0;
      endcase
    end
  end

  // Set when the CSR write enters pre-decode, cleared once the bubble goes out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_stall_q <= 1'b0;
    end else if (bu_flush_i) begin
      csr_stall_q <= 1'b0;
    end else if (!id_stall_i) begin
      if (csr_stall_q) begin
        csr_stall_q <= 1'b0;
      end else begin
        csr_stall_q <= csr_write & ~if_insn_i.bubble & ~redir_hold;
      end
    end
  end

  assign local_stall = csr_stall_q | redir_hold;
  assign pd_stall_o  = id_stall_i | local_stall;

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  // Flush first, then exception kill, then issue hold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_insn_o.instr  <= INSTR_NOP;
      pd_insn_o.bubble <= 1'b1;
      pd_pc_o          <= PC_INIT;
      pd_pred_taken_o  <= 1'b0;
    end else if (bu_flush_i) begin
      pd_insn_o.bubble <= 1'b1;
      pd_pc_o          <= bu_nxt_pc_i;
      pd_pred_taken_o  <= 1'b0;
    end else if (id_except_i.any) begin
      pd_insn_o.bubble <= 1'b1;
      pd_pred_taken_o  <= 1'b0;
    end else if (!id_stall_i) begin
      pd_insn_o.instr  <= if_insn_i.instr;
      pd_pc_o          <= if_pc_i;
      // Local stall turns this slot into a bubble, fetch replays the word
      pd_insn_o.bubble <= if_insn_i.bubble | local_stall;
      pd_pred_taken_o  <= branch_taken & ~local_stall;
    end
  end

  // One latch per taken prediction
  a_strobe_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_latch_nxt_pc_o |=> !pd_latch_nxt_pc_o);

endmodule

/* design/rv_issue.sv */
// Opcode-level decode only; after an illegal opcode nothing issues until bu_flush_i
`timescale 1ns/1ns

module rv_issue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   id_stall_i,
  input  logic                   bu_flush_i,

  // From pre-decode
  input  rv_pipe_pkg::insn_t     pd_insn_i,
  input  rv_pipe_pkg::pc_t       pd_pc_i,
  input  logic                   pd_pred_taken_i,

  // Held while id_stall_i is high; a record is taken when valid and not stalled
  output rv_pipe_pkg::id_op_t    id_op_o,
  output rv_pipe_pkg::except_t   id_except_o
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  id_op_t  op_d;
  opcode_t opcode;
  logic    live;
  logic    illegal;
  logic    halt_q;

  assign opcode = get_opcode(pd_insn_i.instr);

  // Nothing new goes out once an illegal opcode has issued
  assign live = ~pd_insn_i.bubble & ~halt_q;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_d            = '0;
    op_d.valid      = live;
    op_d.pc         = pd_pc_i;
    op_d.rd         = get_rd(pd_insn_i.instr);
    op_d.rs1        = get_rs1(pd_insn_i.instr);
    op_d.rs2        = get_rs2(pd_insn_i.instr);
    op_d.pred_taken = pd_pred_taken_i;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        op_d.op_class = UPPER;
        op_d.imm      = imm_u(pd_insn_i.instr);
      end
      OPC_JAL: begin
        op_d.op_class = JUMP;
        op_d.imm      = imm_j(pd_insn_i.instr);
      end
      // JALR keeps the I-type offset
      OPC_JALR: begin
        op_d.op_class = JUMP;
        op_d.imm      = imm_i(pd_insn_i.instr);
      end
      OPC_BRANCH: begin
        op_d.op_class = BRANCH;
        op_d.imm      = imm_b(pd_insn_i.instr);
      end
      OPC_LOAD: begin
        op_d.op_class = LOAD;
        op_d.imm      = imm_i(pd_insn_i.instr);
      end
      OPC_STORE: begin
        op_d.op_class = STORE;
        op_d.imm      = imm_s(pd_insn_i.instr);
      end
      OPC_OPIMM: begin
        op_d.op_class = ALU_IMM;
        op_d.imm      = imm_i(pd_insn_i.instr);
      end
      // Register form, imm stays zero
      OPC_OP: op_d.op_class = ALU_REG;
      // CSR address rides in imm
      OPC_SYSTEM: begin
        op_d.op_class = SYSTEM;
        op_d.imm      = imm_i(pd_insn_i.instr);
      end
      default: op_d.op_class = NONE;
    endcase
    illegal = live & (op_d.op_class == NONE);
  end

  //////////////////////////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_op_o     <= '0;
      id_except_o <= '0;
      halt_q      <= 1'b0;
    end else if (bu_flush_i) begin
      id_op_o.valid <= 1'b0;
      id_except_o   <= '0;
      halt_q        <= 1'b0;
    end else if (!id_stall_i) begin
      id_op_o             <= op_d;
      id_except_o.illegal <= illegal;
      id_except_o.any     <= illegal;
      halt_q              <= halt_q | illegal;
    end else begin
      // Exception is a single-cycle pulse
      id_except_o <= '0;
    end
  end

  // A killed slot from pre-decode never turns into a valid record
  a_bubble_invalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pd_insn_i.bubble && !id_stall_i && !bu_flush_i |=> !id_op_o.valid);

endmodule

/* design/rv_frontend.sv */
// Fetch to issue in two cycles; stall_i is the downstream back-pressure and freezes the whole front end
`timescale 1ns/1ns

module rv_frontend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   stall_i,

  // Branch-unit redirect
  input  logic                   bu_flush_i,
  input  rv_pipe_pkg::pc_t       bu_nxt_pc_i,

  // Instruction memory
  output rv_pipe_pkg::pc_t       imem_addr_o,
  input  rv_isa_pkg::instr_t     imem_data_i,

  // Issue output
  output rv_pipe_pkg::id_op_t    id_op_o,
  output rv_pipe_pkg::except_t   id_except_o
);

  import rv_pipe_pkg::*;

  // Fetch to pre-decode
  insn_t if_insn;
  pc_t   if_pc;

  // Pre-decode to fetch
  logic  pd_stall;
  logic  pd_flush;
  pc_t   pd_nxt_pc;
  logic  pd_latch_nxt_pc;

  // Pre-decode to issue
  insn_t pd_insn;
  pc_t   pd_pc;
  logic  pd_pred_taken;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  rv_fetch u_fetch (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pd_stall_i        (pd_stall),
    .pd_flush_i        (pd_flush),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pd_latch_nxt_pc_i (pd_latch_nxt_pc),
    .pd_nxt_pc_i       (pd_nxt_pc),
    .imem_addr_o       (imem_addr_o),
    .imem_data_i       (imem_data_i),
    .if_insn_o         (if_insn),
    .if_pc_o           (if_pc)
  );

  rv_predecode u_predecode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (stall_i),
    .pd_stall_o        (pd_stall),
    .bu_flush_i        (bu_flush_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pd_flush_o        (pd_flush),
    .if_insn_i         (if_insn),
    .if_pc_i           (if_pc),
    .id_except_i       (id_except_o),
    .pd_insn_o         (pd_insn),
    .pd_pc_o           (pd_pc),
    .pd_nxt_pc_o       (pd_nxt_pc),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc),
    .pd_pred_taken_o   (pd_pred_taken)
  );

  rv_issue u_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (stall_i),
    .bu_flush_i        (bu_flush_i),
    .pd_insn_i         (pd_insn),
    .pd_pc_i           (pd_pc),
    .pd_pred_taken_i   (pd_pred_taken),
    .id_op_o           (id_op_o),
    .id_except_o       (id_except_o)
  );

endmodule

/* test/tb_frontend.sv */
// Self-checking front-end testbench; memory is combinational, stalls are random, flushes are table driven
`timescale 1ns/1ns

module tb_frontend;

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int WAIT_LIMIT = 60;
  localparam int PROG_MAX   = 32;

  // Expected issue record plus the action taken after it
  typedef struct packed {
    pc_t       pc;
    op_class_e op_class;
    xlen_t     imm;
    reg_t      rd;
    reg_t      rs1;
    reg_t      rs2;
    logic      pred_taken;
    logic      gap_check;
    logic [1:0] gap;
    logic      except;
    logic      flush;
    pc_t       flush_pc;
  } expect_t;

  logic    clk_i = 1'b0;
  logic    rst_ni;
  logic    stall_i;
  logic    bu_flush_i;
  pc_t     bu_nxt_pc_i;
  pc_t     imem_addr;
  instr_t  imem_data;
  id_op_t  id_op;
  except_t id_except;

  // Program table
  pc_t     prog_addr [PROG_MAX];
  instr_t  prog_word [PROG_MAX];
  int      prog_len = 0;

  // Expected issue sequence
  string   name_q [$];
  expect_t exp_q [$];

  int      seed = 23479;
  // Seen exception fields, {illegal, any}
  logic [1:0] except_seen = 2'b00;
  bit      test_bad;
  int      run_cnt = 0;
  int      fail_cnt = 0;
  bit      timed_out = 1'b0;

  always #5 clk_i = ~clk_i;

  rv_frontend dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .bu_flush_i  (bu_flush_i),
    .bu_nxt_pc_i (bu_nxt_pc_i),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .id_op_o     (id_op),
    .id_except_o (id_except)
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction memory model
  //////////////////////////////////////////////////////////////////////

  // Same-cycle answer, NOP outside the table
  always_comb begin
    imem_data = INSTR_NOP;
    for (int k = 0; k < PROG_MAX; k++) begin
      if (k < prog_len && prog_addr[k] == imem_addr) begin
        imem_data = prog_word[k];
      end
    end
  end

  task automatic add_word(input pc_t addr, input instr_t word);
    prog_addr[prog_len] = addr;
    prog_word[prog_len] = word;
    prog_len++;
  endtask

  task automatic add_expect(input string name, input pc_t pc, input op_class_e cls,
                            input xlen_t imm, input reg_t rd, input reg_t rs1,
                            input reg_t rs2, input logic pt, input int gap,
                            input logic exc, input logic flush, input pc_t fpc);
    expect_t e;
    e.pc         = pc;
    e.op_class   = cls;
    e.imm        = imm;
    e.rd         = rd;
    e.rs1        = rs1;
    e.rs2        = rs2;
    e.pred_taken = pt;
    // Negative gap means the slot count is not checked
    e.gap_check  = (gap >= 0);
    e.gap        = 2'(gap);
    e.except     = exc;
    e.flush      = flush;
    e.flush_pc   = fpc;
    name_q.push_back(name);
    exp_q.push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and sampling
  //////////////////////////////////////////////////////////////////////

  // One falling edge: new stall, flush control, exception sample
  task automatic step_cycle(input logic flush, input pc_t pc);
    int rnd;
    @(negedge clk_i);
    rnd         = $random(seed);
    stall_i     = (rnd[1:0] == 2'b00);
    bu_flush_i  = flush;
    bu_nxt_pc_i = pc;
    except_seen = except_seen | {id_except.illegal, id_except.any};
  endtask

  // Record is taken at the next rising edge when valid and not stalled
  // Empty unstalled slots on the way are counted
  task automatic wait_issue(output id_op_t op, output int gap, output bit ok);
    int n;
    n   = 0;
    gap = 0;
    ok  = 1'b0;
    op  = '0;
    while (!ok && n < WAIT_LIMIT) begin
      step_cycle(1'b0, '0);
      if (!stall_i && id_op.valid) begin
        op = id_op;
        ok = 1'b1;
      end else if (!stall_i) begin
        gap++;
      end
      n++;
    end
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s: %s expected %h, actual %h", test, field, expected, actual);
      test_bad = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program and expected issue order
  //////////////////////////////////////////////////////////////////////

  initial begin
    id_op_t op;
    int     gap;
    bit     ok;
    expect_t e;

    rst_ni      = 1'b0;
    stall_i     = 1'b0;
    bu_flush_i  = 1'b0;
    bu_nxt_pc_i = '0;

    // Straight line, CSR pair, JAL over 0x224
    add_word(32'h200, 32'h00500093);  // addi x1,x0,5
    add_word(32'h204, 32'hFFD08113);  // addi x2,x1,-3
    add_word(32'h208, 32'h002081B3);  // add x3,x1,x2
    add_word(32'h20C, 32'hFF80A203);  // lw x4,-8(x1)
    add_word(32'h210, 32'hFE412623);  // sw x4,-20(x2)
    add_word(32'h214, 32'h123452B7);  // lui x5,0x12345
    add_word(32'h218, 32'h30009373);  // csrrw x6,0x300,x1
    add_word(32'h21C, 32'h300023F3);  // csrrs x7,0x300,x0
    add_word(32'h220, 32'h020000EF);  // jal x1,+0x20
    add_word(32'h224, 32'h00100493);  // never fetched
    // Forward branch falls through, backward branch loops
    add_word(32'h240, 32'h00000463);  // beq x0,x0,+8
    add_word(32'h244, 32'h00700513);  // addi x10,x0,7
    add_word(32'h248, 32'hFE009EE3);  // bne x1,x0,-4
    // Flush target, then an unknown opcode
    add_word(32'h280, 32'hFFF06593);  // ori x11,x0,-1
    add_word(32'h284, 32'hFFFFF617);  // auipc x12,0xFFFFF
    add_word(32'h288, 32'h1234507F);  // opcode 0x7f
    add_word(32'h28C, 32'h00100493);  // dropped
    add_word(32'h300, 32'h7FF00713);  // addi x14,x0,0x7ff

    // Register fields are the raw slots, whatever the format uses
    add_expect("addi_pos", 32'h200, ALU_IMM, 32'h00000005, 5'd1, 5'd0, 5'd5,
               1'b0, -1, 1'b0, 1'b0, 32'h0);
    add_expect("addi_neg", 32'h204, ALU_IMM, 32'hFFFFFFFD, 5'd2, 5'd1, 5'd29,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("add_reg", 32'h208, ALU_REG, 32'h00000000, 5'd3, 5'd1, 5'd2,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("lw_neg", 32'h20C, LOAD, 32'hFFFFFFF8, 5'd4, 5'd1, 5'd24,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("sw_neg", 32'h210, STORE, 32'hFFFFFFEC, 5'd12, 5'd2, 5'd4,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("lui", 32'h214, UPPER, 32'h12345000, 5'd5, 5'd8, 5'd3,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("csrrw", 32'h218, SYSTEM, 32'h00000300, 5'd6, 5'd1, 5'd0,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    // One empty slot behind the CSR write, none behind csrrs with x0
    add_expect("csrrs_x0", 32'h21C, SYSTEM, 32'h00000300, 5'd7, 5'd0, 5'd0,
               1'b0, 1, 1'b0, 1'b0, 32'h0);
    add_expect("jal", 32'h220, JUMP, 32'h00000020, 5'd1, 5'd0, 5'd0,
               1'b1, 0, 1'b0, 1'b0, 32'h0);
    add_expect("beq_fwd", 32'h240, BRANCH, 32'h00000008, 5'd8, 5'd0, 5'd0,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("addi_fall", 32'h244, ALU_IMM, 32'h00000007, 5'd10, 5'd0, 5'd7,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("bne_back", 32'h248, BRANCH, 32'hFFFFFFFC, 5'd29, 5'd1, 5'd0,
               1'b1, 0, 1'b0, 1'b0, 32'h0);
    add_expect("loop_tgt", 32'h244, ALU_IMM, 32'h00000007, 5'd10, 5'd0, 5'd7,
               1'b0, 0, 1'b0, 1'b1, 32'h280);
    // Two empty slots refill the pipe after a flush
    add_expect("ori_flush", 32'h280, ALU_IMM, 32'hFFFFFFFF, 5'd11, 5'd0, 5'd31,
               1'b0, 2, 1'b0, 1'b0, 32'h0);
    add_expect("auipc", 32'h284, UPPER, 32'hFFFFF000, 5'd12, 5'd31, 5'd31,
               1'b0, 0, 1'b0, 1'b0, 32'h0);
    add_expect("illegal", 32'h288, NONE, 32'h00000000, 5'd0, 5'd8, 5'd3,
               1'b0, 0, 1'b1, 1'b1, 32'h300);
    add_expect("resume", 32'h300, ALU_IMM, 32'h000007FF, 5'd14, 5'd0, 5'd31,
               1'b0, 2, 1'b0, 1'b0, 32'h0);

    // Reset for two cycles, released on a falling edge
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Collect and compare
    //////////////////////////////////////////////////////////////////////

    for (int t = 0; t < exp_q.size() && !timed_out; t++) begin
      e        = exp_q[t];
      test_bad = 1'b0;
      run_cnt++;
      wait_issue(op, gap, ok);
      if (!ok) begin
        $display("timeout: no instruction was issued in time for test %s", name_q[t]);
        timed_out = 1'b1;
        fail_cnt++;
      end else begin
        check_value(name_q[t], "pc", e.pc, op.pc);
        check_value(name_q[t], "op_class", 32'(e.op_class), 32'(op.op_class));
        check_value(name_q[t], "imm", e.imm, op.imm);
        check_value(name_q[t], "rd", 32'(e.rd), 32'(op.rd));
        check_value(name_q[t], "rs1", 32'(e.rs1), 32'(op.rs1));
        check_value(name_q[t], "rs2", 32'(e.rs2), 32'(op.rs2));
        check_value(name_q[t], "pred_taken", 32'(e.pred_taken), 32'(op.pred_taken));
        check_value(name_q[t], "except", 32'({e.except, e.except}), 32'(except_seen));
        if (e.gap_check) begin
          check_value(name_q[t], "empty slots", 32'(e.gap), gap);
        end
        except_seen = 2'b00;
        if (test_bad) begin
          fail_cnt++;
          $display("test %s: mismatch", name_q[t]);
        end else begin
          $display("test %s: ok", name_q[t]);
        end
        // Branch-unit redirect right behind this record
        if (e.flush) begin
          step_cycle(1'b1, e.flush_pc);
        end
      end
    end

    $display("%0d tests run, %0d passed, %0d failed", run_cnt, run_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* all.f */
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_fetch.sv
design/rv_predecode.sv
design/rv_issue.sv
design/rv_frontend.sv
test/tb_frontend.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_frontend \
		-f all.f --Mdir obj_dir -o tb_frontend
	./obj_dir/tb_frontend > sim.log 2>&1 || echo "Test failures found" >> sim.log
	cat sim.log
	! grep -q "Test failures found" sim.log

clean:
	rm -rf obj_dir sim.log
